// File: verilog.f
+incdir+.
nic_rx_pkg.sv
rx_mac_interface.sv
rx_frame_buffer.sv
rx_tlp_trigger.sv
rx_dma_reader.sv
rx_frame_stats.sv
nic_rx_top.sv
nic_rx_checker.sv
tb_nic_rx.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_nic_rx \
    -f verilog.f -o sim_nic_rx > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_nic_rx > sim.log 2>&1
cat sim.log
grep -qx "TB PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: tb_nic_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "nic_rx_params.svh"

module tb_nic_rx;
    import nic_rx_pkg::*;

    localparam int NUM_TESTS = 8;
    localparam int CAPACITY  = (1 << `RX_BUF_AW) - 1;     // One slot always free

    logic        xaui_clk_156_25_out;
    logic        reset_n;
    qword_t      rx_data;
    qmask_t      rx_data_valid;
    logic        rx_good_frame;
    logic        rx_bad_frame;
    logic        host_ready;
    qword_t      tlp_data;
    logic        tlp_valid;
    logic        tlp_sof;
    logic        tlp_eof;
    logic [31:0] good_frames;
    logic [31:0] bad_frames;
    logic [31:0] dropped_frames;

    // --------------------
    // Test table
    // --------------------
    string  t_name [NUM_TESTS];
    int     t_frames [NUM_TESTS];
    int     t_len [NUM_TESTS];          // Qwords per frame
    int     t_bad_mask [NUM_TESTS];     // Bit i marks frame i bad
    int     t_host [NUM_TESTS];         // 0 ready, 1 held low, 2 toggling
    int     t_d_good [NUM_TESTS];       // Expected counter deltas
    int     t_d_bad [NUM_TESTS];
    int     t_d_drop [NUM_TESTS];

    qword_t model_q [$];                // Beats still owed by the DUT
    qword_t exp_beat;
    string  cur_name;
    int     host_mode;
    int     held_qwords;                // Accepted but unread while host low
    int     seed;
    int     errors;
    int     fails;
    int     beats;                      // Beats in the open transfer
    logic   in_xfer;
    int     cycle_cnt;
    int     cycle_limit;

    nic_rx_top u_dut (.*);

    bind nic_rx_top nic_rx_checker u_checker (
        .xaui_clk_156_25_out(xaui_clk_156_25_out),
        .reset_n            (reset_n),
        .tlp_valid          (tlp_valid),
        .tlp_sof            (tlp_sof),
        .tlp_eof            (tlp_eof),
        .trigger_tlp        (trigger_tlp),
        .trigger_tlp_ack    (trigger_tlp_ack),
        .qwords_to_send     (qwords_to_send)
    );

    always #4 xaui_clk_156_25_out = ~xaui_clk_156_25_out;   // 8 ns period

    always @(posedge xaui_clk_156_25_out) cycle_cnt <= cycle_cnt + 1;

    task automatic add_row(input int idx, input string name, input int frames,
                           input int len, input int bad_mask, input int host,
                           input int d_good, input int d_bad, input int d_drop);
        t_name[idx]     = name;
        t_frames[idx]   = frames;
        t_len[idx]      = len;
        t_bad_mask[idx] = bad_mask;
        t_host[idx]     = host;
        t_d_good[idx]   = d_good;
        t_d_bad[idx]    = d_bad;
        t_d_drop[idx]   = d_drop;
    endtask

    // Next edge, then host_ready for this cycle
    task automatic step_cycle();
        @(posedge xaui_clk_156_25_out);
        #1;
        case (host_mode)
            1:       host_ready = 1'b0;
            2:       host_ready = 1'($random(seed));     // Random stall pattern
            default: host_ready = 1'b1;
        endcase
    endtask

    task automatic send_frame(input int len, input bit good);
        qword_t words [$];
        qword_t w;
        bit     accept;
        for (int i = 0; i < len; i++) begin
            step_cycle();
            w             = {$random(seed), $random(seed)};
            rx_data       = w;
            rx_data_valid = 8'hff;
            words.push_back(w);
        end
        step_cycle();
        rx_data_valid = '0;
        rx_good_frame = good;                            // End strobe after data
        rx_bad_frame  = !good;
        // Ring only fills up while the host holds the reader off
        accept = good && ((host_mode != 1) || (held_qwords + len <= CAPACITY));
        if (accept) begin
            foreach (words[i]) model_q.push_back(words[i]);
            if (host_mode == 1) held_qwords += len;
        end
        step_cycle();
        rx_good_frame = 1'b0;
        rx_bad_frame  = 1'b0;
        repeat (4) step_cycle();                         // Inter frame gap
    endtask

    task automatic drain();
        while (model_q.size() != 0) step_cycle();        // Watchdog bounds this
        repeat (10) step_cycle();                        // Last commit settles
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        assert (exp == act) else begin
            $display("CHECK FAILED %s %s: expected %0d actual %0d", cur_name, what, exp, act);
            errors++;
        end
    endtask

    // --------------------
    // Output monitor
    // --------------------
    always @(negedge xaui_clk_156_25_out) begin
        if (reset_n && tlp_valid) begin
            if (tlp_sof) begin
                assert (!in_xfer) else begin
                    $display("Test %s: sof came inside an open transfer", cur_name);
                    errors++;
                end
                in_xfer = 1'b1;
                beats   = 0;
            end
            assert (in_xfer) else begin
                $display("Test %s: beat came without a preceding sof", cur_name);
                errors++;
            end
            beats++;
            assert (model_q.size() != 0) else begin
                $display("Test %s: beat %h came with nothing expected", cur_name, tlp_data);
                errors++;
            end
            if (model_q.size() != 0) begin
                exp_beat = model_q.pop_front();
                assert (tlp_data == exp_beat) else begin
                    $display("CHECK FAILED %s data: expected %h actual %h",
                             cur_name, exp_beat, tlp_data);
                    errors++;
                end
            end
            if (tlp_eof) begin
                assert (beats >= 1 && beats <= `MAX_TLP_QWORDS) else begin
                    $display("CHECK FAILED %s transfer length: expected 1 to %0d actual %0d",
                             cur_name, `MAX_TLP_QWORDS, beats);
                    errors++;
                end
                in_xfer = 1'b0;
            end
        end
    end

    initial begin
        int base_good;
        int base_bad;
        int base_drop;
        int base_err;
        int total_q;
        seed          = 32'h9417;
        errors        = 0;
        fails         = 0;
        beats         = 0;
        in_xfer       = 1'b0;
        cycle_cnt     = 0;
        host_mode     = 0;
        held_qwords   = 0;
        cur_name      = "reset";
        xaui_clk_156_25_out = 1'b0;
        reset_n       = 1'b0;
        rx_data       = '0;
        rx_data_valid = '0;
        rx_good_frame = 1'b0;
        rx_bad_frame  = 1'b0;
        host_ready    = 1'b1;
        //      idx name           frm len bad   host good bad drop
        add_row(0, "single_1",     1,  1,  0,    0,   1,   0,  0);
        add_row(1, "single_7",     1,  7,  0,    0,   1,   0,  0);
        add_row(2, "single_16",    1,  16, 0,    0,   1,   0,  0);
        add_row(3, "bad_between",  3,  5,  'b010, 0,  2,   1,  0);
        add_row(4, "long_40",      1,  40, 0,    0,   1,   0,  0);
        add_row(5, "ring_wrap",    6,  13, 0,    0,   6,   0,  0);
        add_row(6, "buffer_full",  8,  10, 0,    1,   8,   0,  2);   // 6 fit in 63
        add_row(7, "host_toggle",  5,  12, 0,    2,   5,   0,  0);
        total_q = 0;
        for (int i = 0; i < NUM_TESTS; i++) total_q += t_frames[i] * t_len[i];
        cycle_limit = 20 * total_q + 2000;
        repeat (2) @(posedge xaui_clk_156_25_out);
        #1 reset_n = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_name    = t_name[t];
            base_good   = good_frames;
            base_bad    = bad_frames;
            base_drop   = dropped_frames;
            base_err    = errors;
            held_qwords = 0;                             // Ring empty after drain
            host_mode   = t_host[t];
            for (int f = 0; f < t_frames[t]; f++) begin
                send_frame(t_len[t], ((t_bad_mask[t] >> f) & 1) == 0);
            end
            if (host_mode == 1) host_mode = 0;           // Release the held host
            drain();
            host_mode = 0;
            check_count("good_frames", t_d_good[t], good_frames - base_good);
            check_count("bad_frames", t_d_bad[t], bad_frames - base_bad);
            check_count("dropped_frames", t_d_drop[t], dropped_frames - base_drop);
            assert (!in_xfer) else begin
                $display("Test %s: a transfer was left open without eof", cur_name);
                errors++;
            end
            if (errors == base_err) begin
                $display("test %s ok", cur_name);
            end else begin
                $display("test %s had %0d errors", cur_name, errors - base_err);
                fails++;
            end
        end
        assert (u_dut.u_checker.fail_count == 0) else begin
            $display("Protocol checker saw %0d assertion failures",
                     u_dut.u_checker.fail_count);
            errors++;
        end
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 NUM_TESTS, fails, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        @(posedge xaui_clk_156_25_out);
        while (cycle_cnt < cycle_limit) @(posedge xaui_clk_156_25_out);
        $display("Run stopped at cycle %0d because the tests did not finish", cycle_cnt);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: nic_rx_checker.sv
`timescale 1ns/1ns
`default_nettype none

module nic_rx_checker (
    input wire                        xaui_clk_156_25_out,
    input wire                        reset_n,
    input wire                        tlp_valid,        // Host side strobes
    input wire                        tlp_sof,
    input wire                        tlp_eof,
    input wire                        trigger_tlp,      // Trigger to reader
    input wire                        trigger_tlp_ack,
    input wire nic_rx_pkg::tlp_len_t  qwords_to_send
);

    int fail_count = 0;              // Failed assertions so far

    // --------------------
    // Output framing
    // --------------------
    reset_quiet: assert property (@(posedge xaui_clk_156_25_out)
        !reset_n |-> !tlp_valid)
        else begin
            $error("tlp_valid high while reset_n is low");
            fail_count++;
        end

    // Frame markers ride on a valid beat only
    marks_need_valid: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        (tlp_sof || tlp_eof) |-> tlp_valid)
        else begin
            $error("tlp_sof or tlp_eof without tlp_valid");
            fail_count++;
        end

    // --------------------
    // Trigger handshake
    // --------------------
    request_held: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        (trigger_tlp && !trigger_tlp_ack) |=> (trigger_tlp && $stable(qwords_to_send)))
        else begin
            $error("trigger_tlp or qwords_to_send changed before the ack");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: nic_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module nic_rx_top (
    input  wire                         xaui_clk_156_25_out,
    input  wire                         reset_n,
    input  wire nic_rx_pkg::qword_t     rx_data,         // MAC receive side
    input  wire nic_rx_pkg::qmask_t     rx_data_valid,
    input  wire                         rx_good_frame,
    input  wire                         rx_bad_frame,
    input  wire                         host_ready,      // Host side level
    output nic_rx_pkg::qword_t          tlp_data,
    output logic                        tlp_valid,
    output logic                        tlp_sof,
    output logic                        tlp_eof,
    output logic [31:0]                 good_frames,
    output logic [31:0]                 bad_frames,
    output logic [31:0]                 dropped_frames
);
    import nic_rx_pkg::*;

    // --------------------
    // Internal nets
    // --------------------
    buf_addr_t wr_addr;
    qword_t    wr_data;
    logic      wr_en;
    buf_addr_t rd_addr;
    qword_t    rd_data;
    buf_addr_t committed_wr_address;
    buf_addr_t committed_rd_address;   // Shared by trigger and MAC side
    logic      trigger_tlp;
    logic      trigger_tlp_ack;
    tlp_len_t  qwords_to_send;
    logic      frame_dropped;

    rx_mac_interface u_mac (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .rx_data             (rx_data),
        .rx_data_valid       (rx_data_valid),
        .rx_good_frame       (rx_good_frame),
        .rx_bad_frame        (rx_bad_frame),
        .committed_rd_address(committed_rd_address),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .wr_en               (wr_en),
        .committed_wr_address(committed_wr_address),
        .frame_dropped       (frame_dropped)
    );

    rx_frame_buffer u_buf (
        .xaui_clk_156_25_out(xaui_clk_156_25_out),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data),
        .wr_en              (wr_en),
        .rd_addr            (rd_addr),
        .rd_data            (rd_data)
    );

    rx_tlp_trigger u_trig (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .committed_wr_address(committed_wr_address),
        .committed_rd_address(committed_rd_address),
        .trigger_tlp_ack     (trigger_tlp_ack),
        .trigger_tlp         (trigger_tlp),
        .qwords_to_send      (qwords_to_send)
    );

    rx_dma_reader u_dma (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .trigger_tlp         (trigger_tlp),
        .qwords_to_send      (qwords_to_send),
        .rd_data             (rd_data),
        .host_ready          (host_ready),
        .trigger_tlp_ack     (trigger_tlp_ack),
        .rd_addr             (rd_addr),
        .committed_rd_address(committed_rd_address),
        .tlp_data            (tlp_data),
        .tlp_valid           (tlp_valid),
        .tlp_sof             (tlp_sof),
        .tlp_eof             (tlp_eof)
    );

    rx_frame_stats u_stats (
        .xaui_clk_156_25_out(xaui_clk_156_25_out),
        .reset_n            (reset_n),
        .rx_good_frame      (rx_good_frame),
        .rx_bad_frame       (rx_bad_frame),
        .frame_dropped      (frame_dropped),
        .good_frames        (good_frames),
        .bad_frames         (bad_frames),
        .dropped_frames     (dropped_frames)
    );

endmodule

`default_nettype wire

// File: rx_frame_stats.sv
`timescale 1ns/1ns
`default_nettype none

module rx_frame_stats (
    input  wire         xaui_clk_156_25_out,
    input  wire         reset_n,
    input  wire         rx_good_frame,    // MAC end strobes
    input  wire         rx_bad_frame,
    input  wire         frame_dropped,    // Overflow drop from MAC interface
    output logic [31:0] good_frames,
    output logic [31:0] bad_frames,
    output logic [31:0] dropped_frames
);

    // Good strobe still counts on a dropped frame
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            good_frames    <= 32'd0;
            bad_frames     <= 32'd0;
            dropped_frames <= 32'd0;
        end else begin
            if (rx_good_frame) begin
                good_frames <= good_frames + 1'b1;
            end
            if (rx_bad_frame) begin
                bad_frames <= bad_frames + 1'b1;
            end
            if (frame_dropped) begin
                dropped_frames <= dropped_frames + 1'b1;   // Buffer full
            end
        end
    end

endmodule

`default_nettype wire

// File: rx_dma_reader.sv
`timescale 1ns/1ns
`default_nettype none

module rx_dma_reader (
    input  wire                         xaui_clk_156_25_out,
    input  wire                         reset_n,
    input  wire                         trigger_tlp,          // From trigger
    input  wire nic_rx_pkg::tlp_len_t   qwords_to_send,
    input  wire nic_rx_pkg::qword_t     rd_data,              // Buffer read port
    input  wire                         host_ready,           // Host accepts beats
    output logic                        trigger_tlp_ack,      // Pulse on leaving idle
    output nic_rx_pkg::buf_addr_t       rd_addr,
    output nic_rx_pkg::buf_addr_t       committed_rd_address,
    output nic_rx_pkg::qword_t          tlp_data,
    output logic                        tlp_valid,
    output logic                        tlp_sof,
    output logic                        tlp_eof
);
    import nic_rx_pkg::*;

    dma_state_t state;
    tlp_len_t   len;             // Latched transfer length
    tlp_len_t   beat_cnt;        // Beats already sent
    logic       last_beat;

    assign trigger_tlp_ack = (state == DMA_IDLE) && trigger_tlp;
    assign tlp_valid       = (state == DMA_READ) && host_ready; // Stalls with host
    assign last_beat       = (beat_cnt == len - 1'b1);
    assign tlp_sof         = tlp_valid && (beat_cnt == '0);
    assign tlp_eof         = tlp_valid && last_beat;
    assign tlp_data        = rd_data;                  // Second pipeline stage

    // --------------------
    // Read address stage
    // --------------------
    // Look ahead one qword when the current beat leaves, else re-read it
    assign rd_addr = committed_rd_address + buf_addr_t'(beat_cnt)
                   + buf_addr_t'(tlp_valid);

    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            state                <= DMA_IDLE;
            len                  <= '0;
            beat_cnt             <= '0;
            committed_rd_address <= '0;
        end else begin
            case (state)
                DMA_IDLE: begin
                    if (trigger_tlp) begin
                        len      <= qwords_to_send;   // First read issued now
                        beat_cnt <= '0;
                        state    <= DMA_READ;
                    end
                end
                DMA_READ: begin
                    if (tlp_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= DMA_COMMIT;      // eof beat just left
                        end
                    end
                end
                DMA_COMMIT: begin
                    committed_rd_address <= committed_rd_address + buf_addr_t'(len);
                    beat_cnt             <= '0;
                    state                <= DMA_IDLE;  // Frees the slots
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rx_tlp_trigger.sv
`timescale 1ns/1ns
`default_nettype none

`include "nic_rx_params.svh"

module rx_tlp_trigger (
    input  wire                         xaui_clk_156_25_out,
    input  wire                         reset_n,
    input  wire nic_rx_pkg::buf_addr_t  committed_wr_address, // Frames ready
    input  wire nic_rx_pkg::buf_addr_t  committed_rd_address, // Already sent
    input  wire                         trigger_tlp_ack,      // Reader took request
    output logic                        trigger_tlp,          // Held until ack
    output nic_rx_pkg::tlp_len_t        qwords_to_send        // Stable with request
);
    import nic_rx_pkg::*;

    trigger_state_t state;
    buf_addr_t      pending;         // Unread committed qwords
    buf_addr_t      prev_rd;         // Last cycle read pointer
    tlp_len_t       capped;
    logic           in_flight;       // Acked but not yet committed
    logic           rd_moved;

    assign pending  = committed_wr_address - committed_rd_address; // Modular distance
    assign capped   = (pending > buf_addr_t'(`MAX_TLP_QWORDS)) ?
                      tlp_len_t'(`MAX_TLP_QWORDS) : tlp_len_t'(pending);
    assign rd_moved = (committed_rd_address != prev_rd);   // Reader commit seen
    assign trigger_tlp = (state == TRIG_WAIT_ACK);

    // --------------------
    // Request FSM
    // --------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            state          <= TRIG_IDLE;
            qwords_to_send <= '0;
            prev_rd        <= '0;
            in_flight      <= 1'b0;
        end else begin
            prev_rd <= committed_rd_address;
            if (rd_moved) begin
                in_flight <= 1'b0;                         // Pending count valid again
            end
            case (state)
                TRIG_IDLE: begin
                    // Stale count while a transfer is still uncommitted
                    if ((pending != '0) && (!in_flight || rd_moved)) begin
                        qwords_to_send <= capped;
                        state          <= TRIG_WAIT_ACK;
                    end
                end
                TRIG_WAIT_ACK: begin
                    if (trigger_tlp_ack) begin
                        in_flight <= 1'b1;
                        state     <= TRIG_IDLE;
                    end
                end
                default: state <= TRIG_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rx_frame_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "nic_rx_params.svh"

module rx_frame_buffer (
    input  wire                         xaui_clk_156_25_out,
    input  wire nic_rx_pkg::buf_addr_t  wr_addr,   // From MAC side
    input  wire nic_rx_pkg::qword_t     wr_data,
    input  wire                         wr_en,
    input  wire nic_rx_pkg::buf_addr_t  rd_addr,   // From DMA side
    output nic_rx_pkg::qword_t          rd_data    // One cycle after rd_addr
);
    import nic_rx_pkg::*;

    localparam int DEPTH = 1 << `RX_BUF_AW;         // 64 slots

    qword_t mem [DEPTH];

    // --------------------
    // Write and read ports
    // --------------------
    always_ff @(posedge xaui_clk_156_25_out) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;                // MAC writer only
        end
        rd_data <= mem[rd_addr];                    // Read every cycle
    end

endmodule

`default_nettype wire

// File: rx_mac_interface.sv
`timescale 1ns/1ns
`default_nettype none

module rx_mac_interface (
    input  wire                         xaui_clk_156_25_out,
    input  wire                         reset_n,
    input  wire nic_rx_pkg::qword_t     rx_data,              // From MAC
    input  wire nic_rx_pkg::qmask_t     rx_data_valid,        // Nonzero with a qword
    input  wire                         rx_good_frame,        // End strobe ok
    input  wire                         rx_bad_frame,         // End strobe error
    input  wire nic_rx_pkg::buf_addr_t  committed_rd_address, // From DMA reader
    output nic_rx_pkg::buf_addr_t       wr_addr,              // To buffer
    output nic_rx_pkg::qword_t          wr_data,              // To buffer
    output logic                        wr_en,                // To buffer
    output nic_rx_pkg::buf_addr_t       committed_wr_address, // To trigger
    output logic                        frame_dropped         // To stats
);
    import nic_rx_pkg::*;

    mac_rx_state_t state;
    buf_addr_t     wr_ptr;           // Where the next qword lands
    buf_addr_t     next_ptr;
    logic          qword_in;
    logic          frame_end;
    logic          would_overflow;

    assign qword_in       = |rx_data_valid;                  // Any lane valid
    assign frame_end      = rx_good_frame | rx_bad_frame;
    assign next_ptr       = wr_ptr + 1'b1;                   // Wraps at ring size
    assign would_overflow = (next_ptr == committed_rd_address); // Keep one slot free

    // --------------------
    // Frame FSM
    // --------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            state                <= RX_IDLE;
            wr_ptr               <= '0;
            wr_addr              <= '0;
            wr_en                <= 1'b0;
            committed_wr_address <= '0;
            frame_dropped        <= 1'b0;
        end else begin
            wr_en         <= 1'b0;                           // Single cycle strobes
            frame_dropped <= 1'b0;
            case (state)
                RX_IDLE, RX_RECV: begin
                    if (frame_end) begin
                        if (rx_good_frame) begin
                            committed_wr_address <= wr_ptr; // Publish whole frame
                        end else begin
                            wr_ptr <= committed_wr_address;  // Discard partial frame
                        end
                        state <= RX_IDLE;
                    end else if (qword_in) begin
                        if (would_overflow) begin
                            state <= RX_DROP;                // No room for this frame
                        end else begin
                            wr_en   <= 1'b1;
                            wr_addr <= wr_ptr;
                            wr_ptr  <= next_ptr;
                            state   <= RX_RECV;
                        end
                    end
                end
                RX_DROP: begin
                    if (frame_end) begin                     // Rest of frame ignored
                        wr_ptr        <= committed_wr_address;
                        frame_dropped <= 1'b1;
                        state         <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data stage lines up with wr_addr and wr_en
    always_ff @(posedge xaui_clk_156_25_out) begin
        if (qword_in) begin
            wr_data <= rx_data;
        end
    end

endmodule

`default_nettype wire

// File: nic_rx_pkg.sv
`default_nettype none

`include "nic_rx_params.svh"

package nic_rx_pkg;

    typedef logic [`RX_BUF_AW-1:0] buf_addr_t;    // Ring index
    typedef logic [`QWORD_W-1:0]   qword_t;       // One MAC beat
    typedef logic [`QMASK_W-1:0]   qmask_t;       // Byte valid lanes
    typedef logic [`TLP_LEN_W-1:0] tlp_len_t;     // Qwords per transfer

    // --------------------
    // FSM encodings
    // --------------------
    typedef enum logic [1:0] {RX_IDLE, RX_RECV, RX_DROP} mac_rx_state_t;
    typedef enum logic {TRIG_IDLE, TRIG_WAIT_ACK} trigger_state_t;
    typedef enum logic [1:0] {DMA_IDLE, DMA_READ, DMA_COMMIT} dma_state_t;

endpackage

`default_nettype wire

// File: nic_rx_params.svh
`ifndef NIC_RX_PARAMS_SVH
`define NIC_RX_PARAMS_SVH

// --------------------
// Ring buffer geometry
// --------------------
`define RX_BUF_AW        6    // 64 qword slots, one always kept free
`define QWORD_W          64   // MAC data path width
`define QMASK_W          8    // One valid bit per byte lane

// --------------------
// Transfer sizing
// --------------------
`define MAX_TLP_QWORDS   16   // Largest transfer toward the host
`define TLP_LEN_W        5    // Holds 1 to 16

`endif
